// File: verilog/soc_cfg_pkg.sv
// soc configuration: address map, memory sizes, bus widths and id code
`default_nettype none

package soc_cfg_pkg;

  // bus widths
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 128;
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned PeriphDataWidth = 32;

  // transaction ids, host side and internal slots
  localparam int unsigned HostIdWidth = 4;
  localparam int unsigned SlotIdWidth = 2;
  localparam int unsigned NumSlots    = 4;

  // address map
  localparam logic [AddrWidth-1:0] L2BaseAddr     = 32'h1C00_0000;
  localparam int unsigned          L2NumBytes     = 4096;
  localparam logic [AddrWidth-1:0] PeriphBaseAddr = 32'h1A10_0000;
  localparam int unsigned          PeriphNumBytes = 32768;

  // peripheral register file
  localparam int unsigned          NumScratch   = 8;
  localparam logic [AddrWidth-1:0] IdCodeOffset = 32'h20;
  localparam logic [31:0]          IdCode       = 32'h249511C3;

endpackage

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
// soc bus payloads: request and response structs for host, internal and peripheral links
`default_nettype none

package soc_bus_pkg;

  // host port, full width, 4-bit transaction id
  typedef struct packed {
    logic                                  write;
    logic [soc_cfg_pkg::AddrWidth-1:0]     addr;
    logic [soc_cfg_pkg::DataWidth-1:0]     wdata;
    logic [soc_cfg_pkg::StrbWidth-1:0]     strb;
    logic [soc_cfg_pkg::HostIdWidth-1:0]   id;
  } host_req_t;

  typedef struct packed {
    logic [soc_cfg_pkg::DataWidth-1:0]     rdata;
    logic                                  err;
    logic [soc_cfg_pkg::HostIdWidth-1:0]   id;
  } host_rsp_t;

  // internal links carry the remapped slot instead of the host id
  typedef struct packed {
    logic                                  write;
    logic [soc_cfg_pkg::AddrWidth-1:0]     addr;
    logic [soc_cfg_pkg::DataWidth-1:0]     wdata;
    logic [soc_cfg_pkg::StrbWidth-1:0]     strb;
    logic [soc_cfg_pkg::SlotIdWidth-1:0]   slot;
  } int_req_t;

  typedef struct packed {
    logic [soc_cfg_pkg::DataWidth-1:0]     rdata;
    logic                                  err;
    logic [soc_cfg_pkg::SlotIdWidth-1:0]   slot;
  } int_rsp_t;

  // narrow peripheral link, no id
  typedef struct packed {
    logic                                      write;
    logic [soc_cfg_pkg::AddrWidth-1:0]         addr;
    logic [soc_cfg_pkg::PeriphDataWidth-1:0]   wdata;
    logic [soc_cfg_pkg::PeriphDataWidth/8-1:0] strb;
  } periph_req_t;

  typedef struct packed {
    logic [soc_cfg_pkg::PeriphDataWidth-1:0] rdata;
  } periph_rsp_t;

endpackage

`default_nettype wire

// File: verilog/soc_id_remap.sv
// id remapper: narrows host ids to internal slots and restores them on responses
`default_nettype none

module soc_id_remap (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  soc_bus_pkg::host_req_t      slv_req_i,
  input  wire logic                   slv_req_valid_i,
  output logic                        slv_req_ready_o,
  output soc_bus_pkg::host_rsp_t      slv_rsp_o,
  output logic                        slv_rsp_valid_o,
  input  wire logic                   slv_rsp_ready_i,
  output soc_bus_pkg::int_req_t       mst_req_o,
  output logic                        mst_req_valid_o,
  input  wire logic                   mst_req_ready_i,
  input  soc_bus_pkg::int_rsp_t       mst_rsp_i,
  input  wire logic                   mst_rsp_valid_i,
  output logic                        mst_rsp_ready_o
);

  logic [soc_cfg_pkg::NumSlots-1:0]    busy_q;
  logic [soc_cfg_pkg::HostIdWidth-1:0] host_id_q [soc_cfg_pkg::NumSlots];
  logic [soc_cfg_pkg::SlotIdWidth-1:0] free_idx;
  logic                                any_free;
  logic                                req_xfer;
  logic                                rsp_xfer;

  // lowest free slot wins
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = soc_cfg_pkg::NumSlots - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        any_free = 1'b1;
        free_idx = i[soc_cfg_pkg::SlotIdWidth-1:0];
      end
    end
  end

  assign mst_req_valid_o = slv_req_valid_i & any_free;
  assign slv_req_ready_o = mst_req_ready_i & any_free;
  assign req_xfer        = slv_req_valid_i & slv_req_ready_o;

  always_comb begin
    mst_req_o.write = slv_req_i.write;
    mst_req_o.addr  = slv_req_i.addr;
    mst_req_o.wdata = slv_req_i.wdata;
    mst_req_o.strb  = slv_req_i.strb;
    mst_req_o.slot  = free_idx;
  end

  // response path, host id comes back from the table
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;
  assign rsp_xfer        = mst_rsp_valid_i & slv_rsp_ready_i;

  always_comb begin
    slv_rsp_o.rdata = mst_rsp_i.rdata;
    slv_rsp_o.err   = mst_rsp_i.err;
    slv_rsp_o.id    = host_id_q[mst_rsp_i.slot];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
    end else begin
      // a freed slot is busy, so it never collides with the allocated one
      if (rsp_xfer) busy_q[mst_rsp_i.slot] <= 1'b0;
      if (req_xfer) busy_q[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer) host_id_q[free_idx] <= slv_req_i.id;
  end

  // every response must belong to an allocated slot
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_rsp_valid_i |-> busy_q[mst_rsp_i.slot]);

endmodule

`default_nettype wire

// File: verilog/soc_addr_decode.sv
// address decoder: routes requests to l2 or peripherals in order, answers unmapped ones
`default_nettype none

module soc_addr_decode (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  soc_bus_pkg::int_req_t       slv_req_i,
  input  wire logic                   slv_req_valid_i,
  output logic                        slv_req_ready_o,
  output soc_bus_pkg::int_rsp_t       slv_rsp_o,
  output logic                        slv_rsp_valid_o,
  input  wire logic                   slv_rsp_ready_i,
  output soc_bus_pkg::int_req_t       l2_req_o,
  output logic                        l2_req_valid_o,
  input  wire logic                   l2_req_ready_i,
  input  soc_bus_pkg::int_rsp_t       l2_rsp_i,
  input  wire logic                   l2_rsp_valid_i,
  output logic                        l2_rsp_ready_o,
  output soc_bus_pkg::int_req_t       periph_req_o,
  output logic                        periph_req_valid_o,
  input  wire logic                   periph_req_ready_i,
  input  soc_bus_pkg::int_rsp_t       periph_rsp_i,
  input  wire logic                   periph_rsp_valid_i,
  output logic                        periph_rsp_ready_o
);

  typedef enum logic [1:0] {
    tgt_l2,
    tgt_periph,
    tgt_err
  } tgt_e;

  tgt_e                                tgt_sel;
  tgt_e                                tgt_q;
  logic [soc_cfg_pkg::SlotIdWidth:0]   cnt_q;
  logic                                can_issue;
  logic                                err_valid_q;
  logic [soc_cfg_pkg::SlotIdWidth-1:0] err_slot_q;
  logic                                err_ready;
  logic                                req_xfer;
  logic                                rsp_xfer;

  always_comb begin
    if (slv_req_i.addr >= soc_cfg_pkg::L2BaseAddr &&
        slv_req_i.addr < soc_cfg_pkg::L2BaseAddr + soc_cfg_pkg::L2NumBytes) begin
      tgt_sel = tgt_l2;
    end else if (slv_req_i.addr >= soc_cfg_pkg::PeriphBaseAddr &&
                 slv_req_i.addr < soc_cfg_pkg::PeriphBaseAddr + soc_cfg_pkg::PeriphNumBytes) begin
      tgt_sel = tgt_periph;
    end else begin
      tgt_sel = tgt_err;
    end
  end

  // only one target may have requests in flight, keeps responses ordered
  assign can_issue = (cnt_q == '0) || (tgt_sel == tgt_q);
  assign err_ready = !err_valid_q || slv_rsp_ready_i;

  assign l2_req_o           = slv_req_i;
  assign periph_req_o       = slv_req_i;
  assign l2_req_valid_o     = slv_req_valid_i && can_issue && tgt_sel == tgt_l2;
  assign periph_req_valid_o = slv_req_valid_i && can_issue && tgt_sel == tgt_periph;

  always_comb begin
    case (tgt_sel)
      tgt_l2:     slv_req_ready_o = can_issue & l2_req_ready_i;
      tgt_periph: slv_req_ready_o = can_issue & periph_req_ready_i;
      default:    slv_req_ready_o = can_issue & err_ready;
    endcase
  end

  // response mux follows the target of the outstanding requests
  always_comb begin
    case (tgt_q)
      tgt_l2: begin
        slv_rsp_o       = l2_rsp_i;
        slv_rsp_valid_o = l2_rsp_valid_i;
      end
      tgt_periph: begin
        slv_rsp_o       = periph_rsp_i;
        slv_rsp_valid_o = periph_rsp_valid_i;
      end
      default: begin
        slv_rsp_o.rdata = '0;
        slv_rsp_o.err   = 1'b1;
        slv_rsp_o.slot  = err_slot_q;
        slv_rsp_valid_o = err_valid_q;
      end
    endcase
  end

  assign l2_rsp_ready_o     = slv_rsp_ready_i && tgt_q == tgt_l2;
  assign periph_rsp_ready_o = slv_rsp_ready_i && tgt_q == tgt_periph;

  assign req_xfer = slv_req_valid_i & slv_req_ready_o;
  assign rsp_xfer = slv_rsp_valid_o & slv_rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q       <= '0;
      tgt_q       <= tgt_l2;
      err_valid_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + req_xfer - rsp_xfer;
      if (req_xfer) tgt_q <= tgt_sel;
      if (req_xfer && tgt_sel == tgt_err) begin
        err_valid_q <= 1'b1;
      end else if (rsp_xfer && tgt_q == tgt_err) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer && tgt_sel == tgt_err) err_slot_q <= slv_req_i.slot;
  end

  // no target may answer a request it never got
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (l2_rsp_valid_i || periph_rsp_valid_i || err_valid_q) |-> cnt_q != '0);

endmodule

`default_nettype wire

// File: verilog/soc_periph_dwc.sv
// peripheral width converter: 128-bit requests to one 32-bit lane and back
`default_nettype none

module soc_periph_dwc (
  input  wire logic                   clk_i,
  input  soc_bus_pkg::int_req_t       slv_req_i,
  input  wire logic                   slv_req_valid_i,
  output logic                        slv_req_ready_o,
  output soc_bus_pkg::int_rsp_t       slv_rsp_o,
  output logic                        slv_rsp_valid_o,
  input  wire logic                   slv_rsp_ready_i,
  output soc_bus_pkg::periph_req_t    mst_req_o,
  output logic                        mst_req_valid_o,
  input  wire logic                   mst_req_ready_i,
  input  soc_bus_pkg::periph_rsp_t    mst_rsp_i,
  input  wire logic                   mst_rsp_valid_i,
  output logic                        mst_rsp_ready_o
);

  logic [1:0]                          lane;
  logic [1:0]                          lane_q;
  logic [soc_cfg_pkg::SlotIdWidth-1:0] slot_q;

  assign lane = slv_req_i.addr[3:2];

  assign mst_req_valid_o = slv_req_valid_i;
  assign slv_req_ready_o = mst_req_ready_i;
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  always_comb begin
    mst_req_o.write = slv_req_i.write;
    mst_req_o.addr  = slv_req_i.addr;
    mst_req_o.wdata = slv_req_i.wdata[lane*32 +: 32];
    mst_req_o.strb  = slv_req_i.strb[lane*4 +: 4];
  end

  // widen into the stored lane, other lanes zero
  always_comb begin
    slv_rsp_o.rdata                 = '0;
    slv_rsp_o.rdata[lane_q*32 +: 32] = mst_rsp_i.rdata;
    slv_rsp_o.err                   = 1'b0;
    slv_rsp_o.slot                  = slot_q;
  end

  // one response in flight at most, new request lands as the old one leaves
  always_ff @(posedge clk_i) begin
    if (slv_req_valid_i && mst_req_ready_i) begin
      lane_q <= lane;
      slot_q <= slv_req_i.slot;
    end
  end

endmodule

`default_nettype wire

// File: verilog/l2_mem.sv
// l2 memory: byte-strobed 128-bit sram with a registered single response
`default_nettype none

module l2_mem (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  soc_bus_pkg::int_req_t       req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  output soc_bus_pkg::int_rsp_t       rsp_o,
  output logic                        rsp_valid_o,
  input  wire logic                   rsp_ready_i
);

  logic [soc_cfg_pkg::DataWidth-1:0] mem_q [soc_cfg_pkg::L2NumBytes/soc_cfg_pkg::StrbWidth];
  logic [7:0]                        line_idx;
  logic                              req_xfer;

  assign line_idx    = req_i.addr[11:4];
  assign req_ready_o = !rsp_valid_o || rsp_ready_i;
  assign req_xfer    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (req_xfer) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      for (int b = 0; b < soc_cfg_pkg::StrbWidth; b++) begin
        if (req_i.write && req_i.strb[b]) mem_q[line_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
      end
      // writes answer with zero data
      rsp_o.rdata <= req_i.write ? '0 : mem_q[line_idx];
      rsp_o.err   <= 1'b0;
      rsp_o.slot  <= req_i.slot;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o));

endmodule

`default_nettype wire

// File: verilog/soc_periph.sv
// soc peripherals: eight scratch registers and a read-only id code register
`default_nettype none

module soc_periph (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  soc_bus_pkg::periph_req_t    req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  output soc_bus_pkg::periph_rsp_t    rsp_o,
  output logic                        rsp_valid_o,
  input  wire logic                   rsp_ready_i
);

  logic [soc_cfg_pkg::PeriphDataWidth-1:0] scratch_q [soc_cfg_pkg::NumScratch];
  logic [soc_cfg_pkg::AddrWidth-1:0]       offset;
  logic [2:0]                              reg_idx;
  logic                                    scratch_hit;
  logic                                    idcode_hit;
  logic                                    req_xfer;

  assign offset      = req_i.addr - soc_cfg_pkg::PeriphBaseAddr;
  assign reg_idx     = offset[4:2];
  assign scratch_hit = offset < soc_cfg_pkg::NumScratch * 4;
  assign idcode_hit  = {offset[31:2], 2'b00} == soc_cfg_pkg::IdCodeOffset;

  assign req_ready_o = !rsp_valid_o || rsp_ready_i;
  assign req_xfer    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
      for (int i = 0; i < soc_cfg_pkg::NumScratch; i++) scratch_q[i] <= '0;
    end else begin
      if (req_xfer) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
      // only scratch registers take writes
      if (req_xfer && req_i.write && scratch_hit) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) scratch_q[reg_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      if (req_i.write) begin
        rsp_o.rdata <= '0;
      end else if (scratch_hit) begin
        rsp_o.rdata <= scratch_q[reg_idx];
      end else if (idcode_hit) begin
        rsp_o.rdata <= soc_cfg_pkg::IdCode;
      end else begin
        rsp_o.rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/pulp_soc.sv
// soc top level: host port through id remap and decoder to l2 memory and peripherals
`default_nettype none

module pulp_soc (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  soc_bus_pkg::host_req_t      host_req_i,
  input  wire logic                   host_req_valid_i,
  output logic                        host_req_ready_o,
  output soc_bus_pkg::host_rsp_t      host_rsp_o,
  output logic                        host_rsp_valid_o,
  input  wire logic                   host_rsp_ready_i
);

  // remapped host link
  soc_bus_pkg::int_req_t    remap_req;
  soc_bus_pkg::int_rsp_t    remap_rsp;
  logic                     remap_req_valid, remap_req_ready;
  logic                     remap_rsp_valid, remap_rsp_ready;

  // l2 link
  soc_bus_pkg::int_req_t    l2_req;
  soc_bus_pkg::int_rsp_t    l2_rsp;
  logic                     l2_req_valid, l2_req_ready;
  logic                     l2_rsp_valid, l2_rsp_ready;

  // wide peripheral link, before the converter
  soc_bus_pkg::int_req_t    pwide_req;
  soc_bus_pkg::int_rsp_t    pwide_rsp;
  logic                     pwide_req_valid, pwide_req_ready;
  logic                     pwide_rsp_valid, pwide_rsp_ready;

  // narrow peripheral link
  soc_bus_pkg::periph_req_t periph_req;
  soc_bus_pkg::periph_rsp_t periph_rsp;
  logic                     periph_req_valid, periph_req_ready;
  logic                     periph_rsp_valid, periph_rsp_ready;

  soc_id_remap i_id_remap (
    .clk_i, .arst_n_i,
    .slv_req_i       (host_req_i),      .slv_req_valid_i (host_req_valid_i),
    .slv_req_ready_o (host_req_ready_o), .slv_rsp_o      (host_rsp_o),
    .slv_rsp_valid_o (host_rsp_valid_o), .slv_rsp_ready_i (host_rsp_ready_i),
    .mst_req_o       (remap_req),       .mst_req_valid_o (remap_req_valid),
    .mst_req_ready_i (remap_req_ready), .mst_rsp_i       (remap_rsp),
    .mst_rsp_valid_i (remap_rsp_valid), .mst_rsp_ready_o (remap_rsp_ready)
  );

  soc_addr_decode i_addr_decode (
    .clk_i, .arst_n_i,
    .slv_req_i          (remap_req),        .slv_req_valid_i    (remap_req_valid),
    .slv_req_ready_o    (remap_req_ready),  .slv_rsp_o          (remap_rsp),
    .slv_rsp_valid_o    (remap_rsp_valid),  .slv_rsp_ready_i    (remap_rsp_ready),
    .l2_req_o           (l2_req),           .l2_req_valid_o     (l2_req_valid),
    .l2_req_ready_i     (l2_req_ready),     .l2_rsp_i           (l2_rsp),
    .l2_rsp_valid_i     (l2_rsp_valid),     .l2_rsp_ready_o     (l2_rsp_ready),
    .periph_req_o       (pwide_req),        .periph_req_valid_o (pwide_req_valid),
    .periph_req_ready_i (pwide_req_ready),  .periph_rsp_i       (pwide_rsp),
    .periph_rsp_valid_i (pwide_rsp_valid),  .periph_rsp_ready_o (pwide_rsp_ready)
  );

  l2_mem i_l2_mem (
    .clk_i, .arst_n_i,
    .req_i       (l2_req),       .req_valid_i (l2_req_valid), .req_ready_o (l2_req_ready),
    .rsp_o       (l2_rsp),       .rsp_valid_o (l2_rsp_valid), .rsp_ready_i (l2_rsp_ready)
  );

  soc_periph_dwc i_dwc_periph (
    .clk_i,
    .slv_req_i       (pwide_req),        .slv_req_valid_i (pwide_req_valid),
    .slv_req_ready_o (pwide_req_ready),  .slv_rsp_o       (pwide_rsp),
    .slv_rsp_valid_o (pwide_rsp_valid),  .slv_rsp_ready_i (pwide_rsp_ready),
    .mst_req_o       (periph_req),       .mst_req_valid_o (periph_req_valid),
    .mst_req_ready_i (periph_req_ready), .mst_rsp_i       (periph_rsp),
    .mst_rsp_valid_i (periph_rsp_valid), .mst_rsp_ready_o (periph_rsp_ready)
  );

  soc_periph i_periph (
    .clk_i, .arst_n_i,
    .req_i       (periph_req),       .req_valid_i (periph_req_valid),
    .req_ready_o (periph_req_ready), .rsp_o       (periph_rsp),
    .rsp_valid_o (periph_rsp_valid), .rsp_ready_i (periph_rsp_ready)
  );

endmodule

`default_nettype wire

// File: dv/tb_pulp_soc.sv
// soc testbench: golden vectors through the host port, ordered response checking
`default_nettype none

module tb_pulp_soc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxVecs      = 64;
  localparam int NumFields    = 7;
  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 5;
  localparam int CyclesPerVec = 20;

  logic                   clk_i;
  logic                   arst_n_i;
  soc_bus_pkg::host_req_t host_req_i;
  logic                   host_req_valid_i;
  logic                   host_req_ready_o;
  soc_bus_pkg::host_rsp_t host_rsp_o;
  logic                   host_rsp_valid_o;
  logic                   host_rsp_ready_i;

  // one entry per field, NumFields entries per vector
  logic [127:0] golden [MaxVecs*NumFields];
  int           xfer_cyc [MaxVecs];
  int           num_vecs;
  int           rsp_idx;
  int           cyc = 0;
  int           value_errs;
  int           proto_errs;
  integer       seed = 64279;
  logic         loaded = 1'b0;

  pulp_soc dut0 (
    .clk_i,
    .arst_n_i,
    .host_req_i,
    .host_req_valid_i,
    .host_req_ready_o,
    .host_rsp_o,
    .host_rsp_valid_o,
    .host_rsp_ready_i
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2.0) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // vectors end at the first write flag that is not 0 or 1
  function automatic int count_vectors();
    int n;
    n = 0;
    while (n < MaxVecs && golden[n*NumFields] <= 1) n++;
    return n;
  endfunction

  function automatic soc_bus_pkg::host_req_t make_req(int v);
    soc_bus_pkg::host_req_t r;
    int                     b;
    b       = v * NumFields;
    r.write = golden[b][0];
    r.addr  = golden[b+1][soc_cfg_pkg::AddrWidth-1:0];
    r.wdata = golden[b+2][soc_cfg_pkg::DataWidth-1:0];
    r.strb  = golden[b+3][soc_cfg_pkg::StrbWidth-1:0];
    r.id    = golden[b+4][soc_cfg_pkg::HostIdWidth-1:0];
    return r;
  endfunction

  // random response back-pressure, ready about three cycles in four
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      host_rsp_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  // responses come back in request order
  always @(posedge clk_i) begin
    int b;
    if (arst_n_i && host_rsp_valid_o && host_rsp_ready_i) begin
      if (rsp_idx >= num_vecs) begin
        $display("response with id %h arrived after all vectors were answered",
                 host_rsp_o.id);
        proto_errs++;
      end else begin
        b = rsp_idx * NumFields;
        if (host_rsp_o.rdata !== golden[b+5][soc_cfg_pkg::DataWidth-1:0]) begin
          $display("** Error: host_rsp_o.rdata vector %0d: got %h, expected %h",
                   rsp_idx, host_rsp_o.rdata, golden[b+5][soc_cfg_pkg::DataWidth-1:0]);
          value_errs++;
        end
        if (host_rsp_o.err !== golden[b+6][0]) begin
          $display("** Error: host_rsp_o.err vector %0d: got %h, expected %h",
                   rsp_idx, host_rsp_o.err, golden[b+6][0]);
          value_errs++;
        end
        if (host_rsp_o.id !== golden[b+4][soc_cfg_pkg::HostIdWidth-1:0]) begin
          $display("** Error: host_rsp_o.id vector %0d: got %h, expected %h",
                   rsp_idx, host_rsp_o.id, golden[b+4][soc_cfg_pkg::HostIdWidth-1:0]);
          value_errs++;
        end
        // at least one cycle between request and response transfer
        if (cyc <= xfer_cyc[rsp_idx]) begin
          $display("response to vector %0d arrived before its request had transferred",
                   rsp_idx);
          proto_errs++;
        end
      end
      rsp_idx++;
    end
  end

  // driver and end of run
  initial begin
    host_req_i       = '0;
    host_req_valid_i = 1'b0;
    host_rsp_ready_i = 1'b0;
    arst_n_i         = 1'b0;
    value_errs       = 0;
    proto_errs       = 0;
    rsp_idx          = 0;
    for (int i = 0; i < MaxVecs; i++) xfer_cyc[i] = 32'h7FFF_FFFF;
    $readmemh("dv/pulp_soc_golden.txt", golden);
    num_vecs = count_vectors();
    loaded   = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    arst_n_i <= 1'b1;
    if (num_vecs == 0) begin
      $display("no request vectors found in the golden file");
      proto_errs++;
    end
    // back to back, next request presented on the edge of the previous transfer
    for (int v = 0; v < num_vecs; v++) begin
      host_req_i       <= make_req(v);
      host_req_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!host_req_ready_o) @(posedge clk_i);
      xfer_cyc[v] <= cyc;
    end
    host_req_valid_i <= 1'b0;
    wait (rsp_idx >= num_vecs);
    // idle tail catches stray responses
    repeat (10) @(posedge clk_i);
    $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the vector count
  initial begin
    wait (loaded);
    repeat (ResetCycles + (num_vecs + 1) * CyclesPerVec) @(posedge clk_i);
    $display("watchdog expired with %0d of %0d responses received", rsp_idx, num_vecs);
    $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/soc_cfg_pkg.sv
verilog/soc_bus_pkg.sv
verilog/soc_id_remap.sv
verilog/soc_addr_decode.sv
verilog/soc_periph_dwc.sv
verilog/l2_mem.sv
verilog/soc_periph.sv
verilog/pulp_soc.sv
dv/tb_pulp_soc.sv

// File: dv/pulp_soc_golden.txt
// columns: write addr wdata strb host_id | expected: rdata err (all hex)
// a line with write flag F ends the vector list
// l2 full line write, then partial strobes and readback
1 1C000000 00112233445566778899AABBCCDDEEFF FFFF 1 0 0
1 1C000000 A0A1A2A3A4A5A6A7A8A9AAABACADAEAF 00F0 2 0 0
1 1C000000 A0A1A2A3A4A5A6A7A8A9AAABACADAEAF 8001 3 0 0
0 1C000000 0 0 4 A011223344556677A8A9AAABCCDDEEAF 0
1 1C000010 0F1E2D3C4B5A69788796A5B4C3D2E1F0 FFFF 5 0 0
1 1C000FF0 DEADBEEFCAFEF00D0123456789ABCDEF FFFF 6 0 0
1 1C000FF0 11111111222222223333333344444444 0F00 7 0 0
0 1C000010 0 0 8 0F1E2D3C4B5A69788796A5B4C3D2E1F0 0
0 1C000FF0 0 0 9 DEADBEEF222222220123456789ABCDEF 0
0 1C000008 0 0 A A011223344556677A8A9AAABCCDDEEAF 0
// scratch registers through each lane
1 1A100000 12345678 000F 1 0 0
1 1A100004 00000000000000009ABCDEF000000000 00F0 2 0 0
1 1A10000C CAFEBABE000000000000000000000000 F000 3 0 0
1 1A100018 000000005A5AA5A50000000000000000 0300 4 0 0
0 1A100000 0 0 5 12345678 0
0 1A100004 0 0 6 9ABCDEF000000000 0
0 1A10000C 0 0 7 CAFEBABE000000000000000000000000 0
0 1A100018 0 0 8 0000A5A50000000000000000 0
0 1A100008 0 0 9 0 0
// id code register, write ignored
1 1A100020 FFFFFFFF 000F A 0 0
0 1A100020 0 0 B 249511C3 0
0 1A100024 0 0 C 0 0
// unmapped addresses, then targets unchanged
1 30000000 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF FFFF D 0 1
0 1C001000 0 0 E 0 1
1 1A108000 12345678 FFFF F 0 1
0 00000000 0 0 0 0 1
0 1C000000 0 0 1 A011223344556677A8A9AAABCCDDEEAF 0
0 1A100000 0 0 2 12345678 0
// alternating targets with one reused host id
1 1C000020 01010101020202020303030304040404 FFFF 3 0 0
1 1A100010 AAAA5555 000F 3 0 0
0 1C000020 0 0 3 01010101020202020303030304040404 0
0 1A100010 0 0 3 AAAA5555 0
0 30000004 0 0 3 0 1
0 1C000FF0 0 0 3 DEADBEEF222222220123456789ABCDEF 0
1 1A100014 7766554400000000 00C0 5 0 0
0 1A100014 0 0 5 7766000000000000 0
0 1C000010 0 0 6 0F1E2D3C4B5A69788796A5B4C3D2E1F0 0
1 1C000010 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000 7 0 0
0 1C000010 0 0 8 0F1E2D3C4B5A69788796A5B4C3D2E1F0 0
0 1A10001C 0 0 9 0 0
F 0 0 0 0 0 0
